// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail unless the pass message is printed"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: source/cpuPkg.sv
// ISA subset only (R-type add/sub/and/or/slt, addi, lw, sw, beq); other encodings decode as no-ops
package cpuPkg;

    // basic widths
    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;
    typedef logic [15:0] immT;

    // primary opcodes, MIPS encodings
    typedef enum logic [5:0] {
        OpRType = 6'h00,
        OpBeq   = 6'h04,
        OpAddi  = 6'h08,
        OpLw    = 6'h23,
        OpSw    = 6'h2b
    } opcodeT;

    // R-type function codes
    typedef enum logic [5:0] {
        FnAdd = 6'h20,
        FnSub = 6'h22,
        FnAnd = 6'h24,
        FnOr  = 6'h25,
        FnSlt = 6'h2a
    } functT;

    // instruction field positions
    localparam int OpcodeMsb = 31;
    localparam int OpcodeLsb = 26;
    localparam int RsMsb     = 25;
    localparam int RsLsb     = 21;
    localparam int RtMsb     = 20;
    localparam int RtLsb     = 16;
    localparam int RdMsb     = 15;
    localparam int RdLsb     = 11;
    localparam int ImmMsb    = 15;
    localparam int ImmLsb    = 0;
    localparam int FunctMsb  = 5;
    localparam int FunctLsb  = 0;

    // register file size
    localparam int RegCount = 32;
    // hard-wired zero register
    localparam regAddrT ZeroReg = 5'd0;

endpackage

// File: source/execStage.sv
// combinational EX stage; forwarding selects come from hazardUnit, slt is signed
module execStage (
    input  pipePkg::idExT    idEx,
    input  pipePkg::fwdSelT  fwdA,
    input  pipePkg::fwdSelT  fwdB,
    input  cpuPkg::wordT     memResult,
    input  cpuPkg::wordT     wbResult,
    output cpuPkg::wordT     aluResult,
    output cpuPkg::wordT     storeData,
    output cpuPkg::wordT     branchTarget,
    output cpuPkg::regAddrT  destReg,
    output logic             branchTaken
);

    cpuPkg::wordT operandA;
    cpuPkg::wordT rtValue;
    cpuPkg::wordT operandB;
    logic         lessThan;

    // forwarding mux, shared by both operands
    function automatic cpuPkg::wordT fwdMux(pipePkg::fwdSelT sel,
                                            cpuPkg::wordT regValue,
                                            cpuPkg::wordT memValue,
                                            cpuPkg::wordT wbValue);
        case (sel)
            pipePkg::FwdMem: return memValue;
            pipePkg::FwdWb:  return wbValue;
            default:         return regValue;
        endcase
    endfunction

    always_comb begin
        operandA = fwdMux(fwdA, idEx.rsData, memResult, wbResult);
        rtValue  = fwdMux(fwdB, idEx.rtData, memResult, wbResult);
    end

    // immediate for addi, lw, sw
    assign operandB = idEx.ctrl.aluSrcImm ? idEx.imm : rtValue;

    // sw stores the forwarded rt
    assign storeData = rtValue;

    assign lessThan = $signed(operandA) < $signed(operandB);

    always_comb begin
        case (idEx.ctrl.aluOp)
            pipePkg::AluAdd: aluResult = operandA + operandB;
            pipePkg::AluSub: aluResult = operandA - operandB;
            pipePkg::AluAnd: aluResult = operandA & operandB;
            pipePkg::AluOr:  aluResult = operandA | operandB;
            pipePkg::AluSlt: aluResult = {31'd0, lessThan};
            default:         aluResult = operandA + operandB;
        endcase
    end

    // beq compares rs against rt, never the immediate
    assign branchTaken = idEx.ctrl.branch && (operandA == rtValue);

    // word offset relative to the delay-free PC+4
    assign branchTarget = idEx.pcPlus4 + {idEx.imm[29:0], 2'b00};

    // R-type writes rd, addi and lw write rt
    assign destReg = idEx.ctrl.regDstRd ? idEx.rd : idEx.rt;

endmodule

// File: source/hazardUnit.sv
// stall on load-use (conservative on rt), forwarding priority MEM over WB, never for r0
module hazardUnit (
    input  cpuPkg::regAddrT  idRs,
    input  cpuPkg::regAddrT  idRt,
    input  pipePkg::idExT    idEx,
    input  pipePkg::exMemT   exMem,
    input  pipePkg::memWbT   memWb,
    output logic             stall,
    output pipePkg::fwdSelT  fwdA,
    output pipePkg::fwdSelT  fwdB
);

    logic loadInEx;

    // source picker for one EX operand
    function automatic pipePkg::fwdSelT pickFwd(cpuPkg::regAddrT src,
                                                pipePkg::exMemT mem,
                                                pipePkg::memWbT wb);
        if (src == cpuPkg::ZeroReg)
            return pipePkg::FwdReg;
        // youngest producer wins
        else if (mem.ctrl.regWrite && mem.destReg == src)
            return pipePkg::FwdMem;
        else if (wb.regWrite && wb.destReg == src)
            return pipePkg::FwdWb;
        else
            return pipePkg::FwdReg;
    endfunction

    // lw in EX writes rt
    assign loadInEx = idEx.ctrl.memRead && idEx.rt != cpuPkg::ZeroReg;

    // one bubble, the load data then comes from WB
    assign stall = loadInEx && (idEx.rt == idRs || idEx.rt == idRt);

    always_comb begin
        fwdA = pickFwd(idEx.rs, exMem, memWb);
        fwdB = pickFwd(idEx.rt, exMem, memWb);
    end

endmodule

// File: source/instrDecoder.sv
// purely combinational; unsupported opcode or funct yields an all-zero control bundle
module instrDecoder (
    input  cpuPkg::wordT  instr,
    output pipePkg::ctrlT ctrl,
    output cpuPkg::wordT  imm
);

    cpuPkg::opcodeT opcode;
    cpuPkg::functT  funct;
    cpuPkg::immT    immField;

    // field extraction
    assign opcode   = cpuPkg::opcodeT'(instr[cpuPkg::OpcodeMsb:cpuPkg::OpcodeLsb]);
    assign funct    = cpuPkg::functT'(instr[cpuPkg::FunctMsb:cpuPkg::FunctLsb]);
    assign immField = instr[cpuPkg::ImmMsb:cpuPkg::ImmLsb];

    // sign extension for addi, lw, sw and beq offsets
    assign imm = {{16{immField[15]}}, immField};

    always_comb begin
        ctrl = '0;
        case (opcode)
            cpuPkg::OpRType: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDstRd = 1'b1;
                case (funct)
                    cpuPkg::FnAdd: ctrl.aluOp = pipePkg::AluAdd;
                    cpuPkg::FnSub: ctrl.aluOp = pipePkg::AluSub;
                    cpuPkg::FnAnd: ctrl.aluOp = pipePkg::AluAnd;
                    cpuPkg::FnOr:  ctrl.aluOp = pipePkg::AluOr;
                    cpuPkg::FnSlt: ctrl.aluOp = pipePkg::AluSlt;
                    // unknown funct, drop back to a no-op
                    default:       ctrl = '0;
                endcase
            end
            cpuPkg::OpAddi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            cpuPkg::OpLw: begin
                // address = base + offset, result from memory
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            cpuPkg::OpSw: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            cpuPkg::OpBeq: begin
                // compare is done in EX on forwarded operands
                ctrl.branch = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// File: source/pipePkg.sv
// pipeline bundles for the 5-stage core; compile after cpuPkg, which supplies the word types
package pipePkg;

    // ALU operation select
    typedef enum logic [2:0] {
        AluAdd = 3'd0,
        AluSub = 3'd1,
        AluAnd = 3'd2,
        AluOr  = 3'd3,
        AluSlt = 3'd4
    } aluOpT;

    // decoded control, all-zero means bubble
    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  aluSrcImm;
        logic  regDstRd;
        logic  branch;
        aluOpT aluOp;
    } ctrlT;

    // operand source for the EX stage
    typedef enum logic [1:0] {
        FwdReg = 2'd0,
        FwdMem = 2'd1,
        FwdWb  = 2'd2
    } fwdSelT;

    typedef struct packed {
        cpuPkg::wordT instr;
        cpuPkg::wordT pcPlus4;
    } ifIdT;

    typedef struct packed {
        ctrlT            ctrl;
        cpuPkg::wordT    rsData;
        cpuPkg::wordT    rtData;
        cpuPkg::wordT    imm;
        cpuPkg::regAddrT rs;
        cpuPkg::regAddrT rt;
        cpuPkg::regAddrT rd;
        cpuPkg::wordT    pcPlus4;
    } idExT;

    typedef struct packed {
        ctrlT            ctrl;
        cpuPkg::wordT    aluResult;
        cpuPkg::wordT    storeData;
        cpuPkg::regAddrT destReg;
    } exMemT;

    typedef struct packed {
        logic            regWrite;
        cpuPkg::regAddrT destReg;
        cpuPkg::wordT    value;
    } memWbT;

endpackage

// File: source/pipelineCpu.sv
// PC resets to 0; memories are external and must answer combinationally in the same cycle
module pipelineCpu (
    input  logic         clk,
    input  logic         reset,
    output cpuPkg::wordT instAddr,
    input  cpuPkg::wordT instr,
    output cpuPkg::wordT dataAddr,
    output cpuPkg::wordT dataWrite,
    output logic         dataWriteEnable,
    output logic         dataReadEnable,
    input  cpuPkg::wordT dataRead
);

    cpuPkg::wordT    pc;
    cpuPkg::wordT    pcPlus4;
    pipePkg::ifIdT   ifIdReg;
    pipePkg::idExT   idExReg;
    pipePkg::idExT   idExNext;
    pipePkg::exMemT  exMemReg;
    pipePkg::memWbT  memWbReg;
    pipePkg::memWbT  memWbNext;
    pipePkg::ctrlT   idCtrl;
    cpuPkg::wordT    idImm;
    cpuPkg::wordT    rsData;
    cpuPkg::wordT    rtData;
    cpuPkg::regAddrT idRs;
    cpuPkg::regAddrT idRt;
    cpuPkg::regAddrT idRd;
    logic            stall;
    pipePkg::fwdSelT fwdA;
    pipePkg::fwdSelT fwdB;
    cpuPkg::wordT    aluResult;
    cpuPkg::wordT    storeData;
    cpuPkg::wordT    branchTarget;
    cpuPkg::regAddrT destReg;
    logic            branchTaken;

    // fetch
    assign instAddr = pc;
    assign pcPlus4  = pc + 32'd4;

    // taken branch beats a stall, the stalled instruction is flushed anyway
    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            pc <= '0;
        else if (branchTaken)
            pc <= branchTarget;
        else if (!stall)
            pc <= pcPlus4;
    end

    // zero word decodes as a no-op, so clearing is a flush
    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            ifIdReg <= '0;
        else if (branchTaken)
            ifIdReg <= '0;
        else if (!stall)
            ifIdReg <= '{instr: instr, pcPlus4: pcPlus4};
    end

    // decode
    assign idRs = ifIdReg.instr[cpuPkg::RsMsb:cpuPkg::RsLsb];
    assign idRt = ifIdReg.instr[cpuPkg::RtMsb:cpuPkg::RtLsb];
    assign idRd = ifIdReg.instr[cpuPkg::RdMsb:cpuPkg::RdLsb];

    instrDecoder u_instrDecoder (
        .instr (ifIdReg.instr),
        .ctrl  (idCtrl),
        .imm   (idImm)
    );

    // write port driven from WB
    regFile u_regFile (
        .clk         (clk),
        .reset       (reset),
        .readAddrA   (idRs),
        .readAddrB   (idRt),
        .readDataA   (rsData),
        .readDataB   (rtData),
        .writeEnable (memWbReg.regWrite),
        .writeAddr   (memWbReg.destReg),
        .writeData   (memWbReg.value)
    );

    hazardUnit u_hazardUnit (
        .idRs  (idRs),
        .idRt  (idRt),
        .idEx  (idExReg),
        .exMem (exMemReg),
        .memWb (memWbReg),
        .stall (stall),
        .fwdA  (fwdA),
        .fwdB  (fwdB)
    );

    assign idExNext = '{ctrl: idCtrl, rsData: rsData, rtData: rtData, imm: idImm,
                        rs: idRs, rt: idRt, rd: idRd, pcPlus4: ifIdReg.pcPlus4};

    // bubble on stall or flush, only the control bundle matters
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            idExReg <= '0;
        end else begin
            idExReg <= idExNext;
            if (branchTaken || stall)
                idExReg.ctrl <= '0;
        end
    end

    // execute
    execStage u_execStage (
        .idEx         (idExReg),
        .fwdA         (fwdA),
        .fwdB         (fwdB),
        .memResult    (exMemReg.aluResult),
        .wbResult     (memWbReg.value),
        .aluResult    (aluResult),
        .storeData    (storeData),
        .branchTarget (branchTarget),
        .destReg      (destReg),
        .branchTaken  (branchTaken)
    );

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            exMemReg <= '0;
        else
            exMemReg <= '{ctrl: idExReg.ctrl, aluResult: aluResult,
                          storeData: storeData, destReg: destReg};
    end

    // memory access, address is the ALU sum
    assign dataAddr        = exMemReg.aluResult;
    assign dataWrite       = exMemReg.storeData;
    assign dataWriteEnable = exMemReg.ctrl.memWrite;
    assign dataReadEnable  = exMemReg.ctrl.memRead;

    // load data or ALU result
    assign memWbNext = '{regWrite: exMemReg.ctrl.regWrite, destReg: exMemReg.destReg,
                         value: exMemReg.ctrl.memToReg ? dataRead : exMemReg.aluResult};

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            memWbReg <= '0;
        else
            memWbReg <= memWbNext;
    end

endmodule

// File: source/regFile.sv
// 2 read / 1 write; r0 reads as zero, a write in the same cycle is visible on the read ports
module regFile (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::regAddrT readAddrA,
    input  cpuPkg::regAddrT readAddrB,
    output cpuPkg::wordT    readDataA,
    output cpuPkg::wordT    readDataB,
    input  logic            writeEnable,
    input  cpuPkg::regAddrT writeAddr,
    input  cpuPkg::wordT    writeData
);

    cpuPkg::wordT regs [cpuPkg::RegCount];

    // one read port, with zero register and write bypass
    function automatic cpuPkg::wordT readPort(cpuPkg::regAddrT addr);
        if (addr == cpuPkg::ZeroReg)
            return '0;
        else if (writeEnable && writeAddr == addr)
            return writeData;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < cpuPkg::RegCount; i++)
                regs[i] <= '0;
        end else if (writeEnable && writeAddr != cpuPkg::ZeroReg) begin
            regs[writeAddr] <= writeData;
        end
    end

    always_comb begin
        readDataA = readPort(readAddrA);
        readDataB = readPort(readAddrB);
    end

endmodule

// File: verif/cpuModel.svh
// sequential ISA model; uses imem, modelMem, expAddr, expData and modelHalted of the including module
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// 16-bit field to a signed word
function automatic cpuPkg::wordT signExtend(cpuPkg::immT value);
    return {{16{value[15]}}, value};
endfunction

// one instruction per step, no pipeline, records every store in order
task automatic runModel();
    cpuPkg::wordT    regs [cpuPkg::RegCount];
    cpuPkg::wordT    pc;
    cpuPkg::wordT    nextPc;
    cpuPkg::wordT    word;
    cpuPkg::wordT    a;
    cpuPkg::wordT    b;
    cpuPkg::wordT    imm;
    cpuPkg::wordT    sum;
    cpuPkg::wordT    result;
    cpuPkg::regAddrT dest;
    logic            writeReg;
    cpuPkg::opcodeT  op;
    cpuPkg::functT   fn;
    int              steps;
    for (int i = 0; i < cpuPkg::RegCount; i++)
        regs[i] = '0;
    pc = '0;
    steps = 0;
    modelHalted = 1'b0;
    while (!modelHalted && steps < ModelStepLimit) begin
        word = imem[pc[ImemIdxMsb:2]];
        op = cpuPkg::opcodeT'(word[cpuPkg::OpcodeMsb:cpuPkg::OpcodeLsb]);
        fn = cpuPkg::functT'(word[cpuPkg::FunctMsb:cpuPkg::FunctLsb]);
        a = regs[word[cpuPkg::RsMsb:cpuPkg::RsLsb]];
        b = regs[word[cpuPkg::RtMsb:cpuPkg::RtLsb]];
        imm = signExtend(word[cpuPkg::ImmMsb:cpuPkg::ImmLsb]);
        sum = a + imm;
        // I-type writes rt by default
        dest = word[cpuPkg::RtMsb:cpuPkg::RtLsb];
        writeReg = 1'b0;
        result = '0;
        nextPc = pc + 32'd4;
        case (op)
            cpuPkg::OpRType: begin
                dest = word[cpuPkg::RdMsb:cpuPkg::RdLsb];
                writeReg = 1'b1;
                case (fn)
                    cpuPkg::FnAdd: result = a + b;
                    cpuPkg::FnSub: result = a - b;
                    cpuPkg::FnAnd: result = a & b;
                    cpuPkg::FnOr:  result = a | b;
                    cpuPkg::FnSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    // unknown funct is a no-op
                    default:       writeReg = 1'b0;
                endcase
            end
            cpuPkg::OpAddi: begin
                result = sum;
                writeReg = 1'b1;
            end
            cpuPkg::OpLw: begin
                result = modelMem[sum[DataIdxMsb:2]];
                writeReg = 1'b1;
            end
            cpuPkg::OpSw: begin
                modelMem[sum[DataIdxMsb:2]] = b;
                expAddr.push_back(sum);
                expData.push_back(b);
            end
            cpuPkg::OpBeq: begin
                if (a == b)
                    nextPc = pc + 32'd4 + (imm << 2);
                // branch onto itself is the halt
                if (nextPc == pc)
                    modelHalted = 1'b1;
            end
            default: ;
        endcase
        // r0 stays zero
        if (writeReg && dest != cpuPkg::ZeroReg)
            regs[dest] = result;
        pc = nextPc;
        steps++;
    end
endtask

`endif

// File: verif/cpuTb.sv
// one random program from seed 42; memories are 64 words each and ignore address bits above 7
module cpuTb;

    localparam int ClkPeriod      = 40;
    localparam int DriveDelay     = 1;
    localparam int ResetCycles    = 3;
    localparam int ImemDepth      = 64;
    localparam int DataDepth      = 64;
    localparam int ImemIdxMsb     = $clog2(ImemDepth) + 1;
    localparam int DataIdxMsb     = $clog2(DataDepth) + 1;
    // registers used by the random program
    localparam int RegPool        = 8;
    localparam int ProgLen        = 60;
    // random body, then one store per pool register, then the halt
    localparam int BodyLen        = ProgLen - 1 - RegPool;
    localparam int HaltVisits     = 4;
    localparam int HaltTimeout    = 2000;
    localparam int ModelStepLimit = 1000;
    localparam cpuPkg::wordT HaltAddr = cpuPkg::wordT'((ProgLen - 1) * 4);

    logic          clk;
    logic          reset;
    cpuPkg::wordT  instAddr;
    cpuPkg::wordT  instr;
    cpuPkg::wordT  dataAddr;
    cpuPkg::wordT  dataWrite;
    logic          dataWriteEnable;
    logic          dataReadEnable;
    cpuPkg::wordT  dataRead;

    cpuPkg::wordT  imem [ImemDepth];
    cpuPkg::wordT  dataMem [DataDepth];
    cpuPkg::wordT  modelMem [DataDepth];
    cpuPkg::wordT  expAddr [$];
    cpuPkg::wordT  expData [$];
    logic          modelHalted;
    int            seed = 42;
    int            storeCount = 0;
    int            addrErrors = 0;
    int            dataErrors = 0;
    int            extraStores = 0;
    int            runErrors = 0;
    int            totalErrors;
    cpuPkg::functT fnList [5] = '{cpuPkg::FnAdd, cpuPkg::FnSub, cpuPkg::FnAnd,
                                  cpuPkg::FnOr, cpuPkg::FnSlt};

    `include "cpuModel.svh"

    pipelineCpu u_pipelineCpu (
        .clk             (clk),
        .reset           (reset),
        .instAddr        (instAddr),
        .instr           (instr),
        .dataAddr        (dataAddr),
        .dataWrite       (dataWrite),
        .dataWriteEnable (dataWriteEnable),
        .dataReadEnable  (dataReadEnable),
        .dataRead        (dataRead)
    );

    // both memories answer in the same cycle
    assign instr    = imem[instAddr[ImemIdxMsb:2]];
    // load data only while the read enable is high, a load without it gets garbage
    assign dataRead = dataReadEnable ? dataMem[dataAddr[DataIdxMsb:2]] : 'x;

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic int randBelow(int n);
        return ($random(seed) & 32'h7fffffff) % n;
    endfunction

    function automatic cpuPkg::immT wordOffset();
        return cpuPkg::immT'(randBelow(DataDepth) * 4);
    endfunction

    function automatic cpuPkg::wordT encR(cpuPkg::functT fn, cpuPkg::regAddrT rs,
                                          cpuPkg::regAddrT rt, cpuPkg::regAddrT rd);
        cpuPkg::wordT w;
        w = '0;
        w[cpuPkg::OpcodeMsb:cpuPkg::OpcodeLsb] = cpuPkg::OpRType;
        w[cpuPkg::RsMsb:cpuPkg::RsLsb] = rs;
        w[cpuPkg::RtMsb:cpuPkg::RtLsb] = rt;
        w[cpuPkg::RdMsb:cpuPkg::RdLsb] = rd;
        w[cpuPkg::FunctMsb:cpuPkg::FunctLsb] = fn;
        return w;
    endfunction

    function automatic cpuPkg::wordT encI(cpuPkg::opcodeT op, cpuPkg::regAddrT rs,
                                          cpuPkg::regAddrT rt, cpuPkg::immT imm);
        cpuPkg::wordT w;
        w = '0;
        w[cpuPkg::OpcodeMsb:cpuPkg::OpcodeLsb] = op;
        w[cpuPkg::RsMsb:cpuPkg::RsLsb] = rs;
        w[cpuPkg::RtMsb:cpuPkg::RtLsb] = rt;
        w[cpuPkg::ImmMsb:cpuPkg::ImmLsb] = imm;
        return w;
    endfunction

    task automatic genProgram();
        int              kind;
        int              maxOff;
        cpuPkg::regAddrT rs;
        cpuPkg::regAddrT rt;
        cpuPkg::regAddrT rd;
        // zero words decode as no-ops past the halt
        for (int i = 0; i < ImemDepth; i++)
            imem[i] = '0;
        for (int i = 0; i < DataDepth; i++) begin
            dataMem[i] = $random(seed);
            modelMem[i] = dataMem[i];
        end
        for (int i = 0; i < BodyLen; i++) begin
            kind = randBelow(10);
            rs = cpuPkg::regAddrT'(randBelow(RegPool));
            rt = cpuPkg::regAddrT'(randBelow(RegPool));
            rd = cpuPkg::regAddrT'(randBelow(RegPool));
            if (kind < 3) begin
                imem[i] = encR(fnList[randBelow(5)], rs, rt, rd);
            end else if (kind < 5) begin
                imem[i] = encI(cpuPkg::OpAddi, rs, rt, cpuPkg::immT'($random(seed)));
            end else if (kind < 7) begin
                imem[i] = encI(cpuPkg::OpLw, cpuPkg::ZeroReg, rt, wordOffset());
            end else if (kind < 9) begin
                imem[i] = encI(cpuPkg::OpSw, cpuPkg::ZeroReg, rt, wordOffset());
            end else begin
                // forward only, never past the first tail store
                maxOff = (BodyLen - i - 1 < 3) ? BodyLen - i - 1 : 3;
                // equal registers half the time, so many branches are taken
                if (randBelow(2) == 0)
                    rt = rs;
                imem[i] = encI(cpuPkg::OpBeq, rs, rt, cpuPkg::immT'(randBelow(maxOff + 1)));
            end
        end
        // dump every pool register, r0 included
        for (int r = 0; r < RegPool; r++)
            imem[BodyLen + r] = encI(cpuPkg::OpSw, cpuPkg::ZeroReg, cpuPkg::regAddrT'(r),
                                     cpuPkg::immT'(r * 4));
        imem[ProgLen - 1] = encI(cpuPkg::OpBeq, cpuPkg::ZeroReg, cpuPkg::ZeroReg, 16'hffff);
    endtask

    task automatic checkAddr(int index, cpuPkg::wordT got, cpuPkg::wordT expected);
        if (got !== expected) begin
            $display("error at %0t: dataAddr of store %0d is 0x%08h, expected 0x%08h",
                     $time, index, got, expected);
            addrErrors++;
        end
    endtask

    task automatic checkWord(int index, cpuPkg::wordT got, cpuPkg::wordT expected);
        if (got !== expected) begin
            $display("error at %0t: dataWrite of store %0d is 0x%08h, expected 0x%08h",
                     $time, index, got, expected);
            dataErrors++;
        end
    endtask

    // halt loop refetches the halt every third cycle
    task automatic waitForHalt();
        int cycles;
        int visits;
        cycles = 0;
        visits = 0;
        while (visits < HaltVisits && cycles < HaltTimeout) begin
            @(negedge clk);
            cycles++;
            if (instAddr == HaltAddr)
                visits++;
        end
        if (visits < HaltVisits) begin
            $display("timeout: instAddr did not reach the halt address 0x%08h in %0d cycles",
                     HaltAddr, HaltTimeout);
            runErrors++;
        end
    endtask

    // mid-cycle, DUT outputs are settled
    always @(negedge clk) begin
        if (reset && dataWriteEnable) begin
            if (storeCount < expAddr.size()) begin
                checkAddr(storeCount, dataAddr, expAddr[storeCount]);
                checkWord(storeCount, dataWrite, expData[storeCount]);
            end else begin
                $display("unexpected store at %0t to 0x%08h, the model has only %0d stores",
                         $time, dataAddr, expAddr.size());
                extraStores++;
            end
            dataMem[dataAddr[DataIdxMsb:2]] = dataWrite;
            storeCount++;
        end
    end

    initial begin
        reset = 1'b0;
        genProgram();
        runModel();
        if (!modelHalted) begin
            $display("model did not reach the halt within %0d steps", ModelStepLimit);
            runErrors++;
        end
        repeat (ResetCycles) @(posedge clk);
        #DriveDelay;
        reset = 1'b1;
        waitForHalt();
        if (storeCount < expAddr.size()) begin
            $display("missing stores: the DUT made %0d, the model expects %0d",
                     storeCount, expAddr.size());
            runErrors++;
        end
        totalErrors = addrErrors + dataErrors + extraStores + runErrors;
        $display("stores %0d of %0d, address errors %0d, data errors %0d, extra %0d, other %0d",
                 storeCount, expAddr.size(), addrErrors, dataErrors, extraStores, runErrors);
        if (totalErrors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: verif/pipelineCpu_checker.sv
// bound into every pipelineCpu; all properties are off while reset is low
module pipelineCpu_checker (
    input logic         clk,
    input logic         reset,
    input cpuPkg::wordT instAddr,
    input cpuPkg::wordT dataAddr,
    input logic         dataWriteEnable,
    input logic         dataReadEnable
);

    // one MEM-stage instruction, either a load or a store
    oneDataOp: assert property (@(posedge clk) disable iff (!reset)
        !(dataWriteEnable && dataReadEnable))
        else $error("data port read and write enables are high together");

    // PC only moves by words
    instAligned: assert property (@(posedge clk) disable iff (!reset)
        instAddr[1:0] == 2'b00)
        else $error("instAddr 0x%08h is not word aligned", instAddr);

    dataAddrKnown: assert property (@(posedge clk) disable iff (!reset)
        (dataWriteEnable || dataReadEnable) |-> !$isunknown(dataAddr))
        else $error("dataAddr has unknown bits during a data access");

endmodule

bind pipelineCpu pipelineCpu_checker u_checker (
    .clk             (clk),
    .reset           (reset),
    .instAddr        (instAddr),
    .dataAddr        (dataAddr),
    .dataWriteEnable (dataWriteEnable),
    .dataReadEnable  (dataReadEnable)
);

// File: vlog.f
+incdir+verif
source/cpuPkg.sv
source/pipePkg.sv
source/instrDecoder.sv
source/regFile.sv
source/hazardUnit.sv
source/execStage.sv
source/pipelineCpu.sv
verif/pipelineCpu_checker.sv
verif/cpuTb.sv
